/* hw/tag_store_config.svh */
/*
  Tag store configuration
  Way count, set index width and tag width shared by the package
  and every tag store module
*/
`ifndef TAG_STORE_CONFIG_SVH
`define TAG_STORE_CONFIG_SVH

// Set associativity, one RAM column per way
`define TS_NUM_WAYS 4

// Set index width, 16 sets
`define TS_INDEX_BITS 4

// Stored tag width
`define TS_TAG_BITS 8

`endif

/* hw/tag_store_pkg.sv */
/*
  Tag store package
  Entry, request and response structs plus the opcode and
  controller state enums
*/
`default_nettype none

`include "tag_store_config.svh"

package tag_store_pkg;

  // One bit per way, one-hot for a selection, multi-hot for lock masks
  typedef logic [`TS_NUM_WAYS-1:0]   way_ind_t;
  typedef logic [`TS_INDEX_BITS-1:0] index_t;
  typedef logic [`TS_TAG_BITS-1:0]   tag_t;

  // What one way holds for one set
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  typedef enum logic [0:0] {
    OP_LOOKUP,
    OP_FLUSH
  } store_op_e;

  // Way field only matters for a flush
  typedef struct packed {
    store_op_e op;
    index_t    index;
    tag_t      tag;
    logic      dirty;
    way_ind_t  way;
  } store_req_t;

  typedef struct packed {
    way_ind_t way;
    logic     hit;
    logic     evict;
    tag_t     evict_tag;
  } store_res_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_RESP,
    ST_WRITE
  } ctrl_state_e;

endpackage

`default_nettype wire

/* hw/tag_ram.sv */
/*
  Tag RAM
  Register array with one entry per set and way. A read returns the
  whole set one cycle after the request, a write updates the flagged ways
*/
`default_nettype none

`include "tag_store_config.svh"

module tag_ram (
  input  wire logic                                             clk_i,
  input  wire logic                                             reset_i,
  input  wire logic                                             req_i,
  input  wire tag_store_pkg::way_ind_t                          we_i,
  input  wire tag_store_pkg::index_t                            index_i,
  input  wire tag_store_pkg::tag_entry_t                        wdata_i,
  output tag_store_pkg::tag_entry_t [`TS_NUM_WAYS-1:0]          rdata_o
);

  localparam int unsigned NumSets = 1 << `TS_INDEX_BITS;

  // Storage indexed by set, then way
  tag_store_pkg::tag_entry_t [NumSets-1:0][`TS_NUM_WAYS-1:0] mem_q;
  // Read data register, holds the last read set
  tag_store_pkg::tag_entry_t [`TS_NUM_WAYS-1:0]              rdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // All entries come up invalid, clean, tag 0
      mem_q   <= '0;
      rdata_q <= '0;
    end else if (req_i) begin
      for (int w = 0; w < `TS_NUM_WAYS; w++) begin
        if (we_i[w]) begin
          mem_q[index_i][w] <= wdata_i;
        end
      end
      // A request with no write enables is a read of the full set
      if (we_i == '0) begin
        rdata_q <= mem_q[index_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* hw/tag_match.sv */
/*
  Tag match
  Compares the request tag against every way of the read set and
  flags the hitting way. Locked ways never hit
*/
`default_nettype none

`include "tag_store_config.svh"

module tag_match (
  input  wire tag_store_pkg::tag_entry_t [`TS_NUM_WAYS-1:0] entries_i,
  input  wire tag_store_pkg::tag_t                          req_tag_i,
  input  wire tag_store_pkg::way_ind_t                      lock_i,
  output tag_store_pkg::way_ind_t                           hit_o,
  output tag_store_pkg::way_ind_t                           dirty_o
);

  for (genvar w = 0; w < `TS_NUM_WAYS; w++) begin : gen_way
    logic tag_equal;

    // Plain equality on the stored tag
    assign tag_equal = (entries_i[w].tag == req_tag_i);

    // Valid, same tag and not reserved as scratchpad
    assign hit_o[w] = entries_i[w].valid & tag_equal & ~lock_i[w];

    // Dirty state goes to the merge for dirty promotion
    assign dirty_o[w] = entries_i[w].dirty;
  end

endmodule

`default_nettype wire

/* hw/victim_select.sv */
/*
  Victim select
  Picks the replacement way among unlocked ways. Prefers an invalid
  way, then a clean way, then the lowest way. Reports a needed eviction
*/
`default_nettype none

`include "tag_store_config.svh"

module victim_select (
  input  wire tag_store_pkg::tag_entry_t [`TS_NUM_WAYS-1:0] entries_i,
  input  wire tag_store_pkg::way_ind_t                      lock_i,
  output tag_store_pkg::way_ind_t                           victim_o,
  output logic                                              evict_o
);

  // Lowest set bit as one-hot, zero when nothing is set
  function automatic tag_store_pkg::way_ind_t lowest_one(input tag_store_pkg::way_ind_t vec);
    tag_store_pkg::way_ind_t sel;
    logic                    found;
    sel   = '0;
    found = 1'b0;
    for (int w = 0; w < `TS_NUM_WAYS; w++) begin
      if (vec[w] && !found) begin
        sel[w] = 1'b1;
        found  = 1'b1;
      end
    end
    return sel;
  endfunction

  tag_store_pkg::way_ind_t valid_vec;
  tag_store_pkg::way_ind_t dirty_vec;
  // Candidate sets in order of preference
  tag_store_pkg::way_ind_t free_ways;
  tag_store_pkg::way_ind_t clean_ways;
  tag_store_pkg::way_ind_t open_ways;

  always_comb begin
    for (int w = 0; w < `TS_NUM_WAYS; w++) begin
      valid_vec[w] = entries_i[w].valid;
      dirty_vec[w] = entries_i[w].dirty;
    end
  end

  assign open_ways  = ~lock_i;
  assign free_ways  = open_ways & ~valid_vec;
  assign clean_ways = open_ways & ~dirty_vec;

  // All ways locked leaves open_ways zero, so no victim
  assign victim_o = (|free_ways)  ? lowest_one(free_ways)  :
                    (|clean_ways) ? lowest_one(clean_ways) :
                                    lowest_one(open_ways);

  // Write back needed only for a valid dirty victim
  assign evict_o = |(victim_o & valid_vec & dirty_vec);

endmodule

`default_nettype wire

/* hw/response_merge.sv */
/*
  Response merge
  Builds the response from match and victim results and decides the
  write-back way and entry. A zero write-back way means no write
*/
`default_nettype none

`include "tag_store_config.svh"

module response_merge (
  input  wire tag_store_pkg::store_op_e                     op_i,
  input  wire tag_store_pkg::way_ind_t                      flush_way_i,
  input  wire tag_store_pkg::tag_t                          req_tag_i,
  input  wire logic                                         req_dirty_i,
  input  wire tag_store_pkg::way_ind_t                      hit_i,
  input  wire tag_store_pkg::way_ind_t                      dirty_i,
  input  wire tag_store_pkg::way_ind_t                      victim_i,
  input  wire logic                                         evict_i,
  input  wire tag_store_pkg::tag_entry_t [`TS_NUM_WAYS-1:0] entries_i,
  output tag_store_pkg::store_res_t                         res_o,
  output tag_store_pkg::way_ind_t                           wr_way_o,
  output tag_store_pkg::tag_entry_t                         wr_entry_o
);

  // One-hot mux over the read set
  function automatic tag_store_pkg::tag_entry_t pick_entry(
    input tag_store_pkg::tag_entry_t [`TS_NUM_WAYS-1:0] entries,
    input tag_store_pkg::way_ind_t                      way
  );
    tag_store_pkg::tag_entry_t sel;
    sel = '0;
    for (int w = 0; w < `TS_NUM_WAYS; w++) begin
      if (way[w]) begin
        sel = tag_store_pkg::tag_entry_t'(sel | entries[w]);
      end
    end
    return sel;
  endfunction

  tag_store_pkg::tag_entry_t victim_entry;
  tag_store_pkg::tag_entry_t flush_entry;
  logic                      hit_dirty;

  assign victim_entry = pick_entry(entries_i, victim_i);
  assign flush_entry  = pick_entry(entries_i, flush_way_i);
  assign hit_dirty    = |(hit_i & dirty_i);

  always_comb begin
    if (op_i == tag_store_pkg::OP_FLUSH) begin
      // Report what the line held, then clear it
      res_o = tag_store_pkg::store_res_t'{way: flush_way_i, hit: 1'b0,
        evict: flush_entry.valid & flush_entry.dirty, evict_tag: flush_entry.tag};
      wr_way_o   = flush_way_i;
      wr_entry_o = '0;
    end else if (|hit_i) begin
      res_o = tag_store_pkg::store_res_t'{way: hit_i, hit: 1'b1, evict: 1'b0, evict_tag: '0};
      // Only promote a clean line to dirty
      wr_way_o   = (req_dirty_i && !hit_dirty) ? hit_i : '0;
      wr_entry_o = tag_store_pkg::tag_entry_t'{valid: 1'b1, dirty: 1'b1, tag: req_tag_i};
    end else begin
      // Miss, new tag replaces the victim
      res_o = tag_store_pkg::store_res_t'{way: victim_i, hit: 1'b0,
        evict: evict_i, evict_tag: victim_entry.tag};
      wr_way_o   = victim_i;
      wr_entry_o = tag_store_pkg::tag_entry_t'{valid: 1'b1, dirty: req_dirty_i, tag: req_tag_i};
    end
  end

endmodule

`default_nettype wire

/* hw/tag_store_ctrl.sv */
/*
  Tag store controller
  FSM for accept, read, respond and write-back. Holds the accepted
  request and the merged response until the handshake completes
*/
`default_nettype none

module tag_store_ctrl (
  input  wire logic                      clk_i,
  input  wire logic                      reset_i,
  input  wire tag_store_pkg::store_req_t req_i,
  input  wire logic                      valid_i,
  output logic                           ready_o,
  input  wire tag_store_pkg::store_res_t res_i,
  input  wire tag_store_pkg::way_ind_t   wr_way_i,
  input  wire tag_store_pkg::tag_entry_t wr_entry_i,
  output logic                           valid_o,
  input  wire logic                      ready_i,
  output tag_store_pkg::store_res_t      res_o,
  output tag_store_pkg::store_req_t      held_req_o,
  output logic                           ram_req_o,
  output tag_store_pkg::way_ind_t        ram_we_o,
  output tag_store_pkg::index_t          ram_index_o,
  output tag_store_pkg::tag_entry_t      ram_wdata_o
);

  tag_store_pkg::ctrl_state_e state_q;
  tag_store_pkg::ctrl_state_e state_d;
  // Payload registers
  tag_store_pkg::store_req_t  req_q;
  tag_store_pkg::store_res_t  res_q;
  tag_store_pkg::way_ind_t    wr_way_q;
  tag_store_pkg::tag_entry_t  wr_entry_q;

  always_comb begin
    state_d     = state_q;
    ready_o     = 1'b0;
    valid_o     = 1'b0;
    ram_req_o   = 1'b0;
    ram_we_o    = '0;
    ram_index_o = req_q.index;
    ram_wdata_o = wr_entry_q;
    unique case (state_q)
      tag_store_pkg::ST_IDLE: begin
        ready_o     = 1'b1;
        // Read is issued on the accepting edge
        ram_index_o = req_i.index;
        if (valid_i) begin
          ram_req_o = 1'b1;
          state_d   = tag_store_pkg::ST_READ;
        end
      end
      tag_store_pkg::ST_READ: begin
        // RAM data valid this cycle, merge result captured at the edge
        state_d = tag_store_pkg::ST_RESP;
      end
      tag_store_pkg::ST_RESP: begin
        valid_o = 1'b1;
        if (ready_i) begin
          state_d = (|wr_way_q) ? tag_store_pkg::ST_WRITE : tag_store_pkg::ST_IDLE;
        end
      end
      tag_store_pkg::ST_WRITE: begin
        ram_req_o = 1'b1;
        ram_we_o  = wr_way_q;
        state_d   = tag_store_pkg::ST_IDLE;
      end
      default: state_d = tag_store_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= tag_store_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request captured on acceptance
  always_ff @(posedge clk_i) begin
    if (state_q == tag_store_pkg::ST_IDLE && valid_i) begin
      req_q <= req_i;
    end
  end

  // Response and write-back captured at the end of the read cycle
  always_ff @(posedge clk_i) begin
    if (state_q == tag_store_pkg::ST_READ) begin
      res_q      <= res_i;
      wr_way_q   <= wr_way_i;
      wr_entry_q <= wr_entry_i;
    end
  end

  assign res_o      = res_q;
  assign held_req_o = req_q;

endmodule

`default_nettype wire

/* hw/tag_store.sv */
/*
  Tag store top
  Set-associative tag storage with lookup and flush. Match and victim
  selection run side by side on the read set
*/
`default_nettype none

`include "tag_store_config.svh"

module tag_store (
  input  wire logic                      clk_i,
  input  wire logic                      reset_i,
  input  wire tag_store_pkg::way_ind_t   spm_lock_i,
  input  wire tag_store_pkg::store_req_t req_i,
  input  wire logic                      valid_i,
  output logic                           ready_o,
  output tag_store_pkg::store_res_t      res_o,
  output logic                           valid_o,
  input  wire logic                      ready_i
);

  tag_store_pkg::store_req_t                         held_req;
  tag_store_pkg::store_res_t                         merged_res;
  tag_store_pkg::way_ind_t                           wr_way;
  tag_store_pkg::tag_entry_t                         wr_entry;
  // RAM port
  logic                                              ram_req;
  tag_store_pkg::way_ind_t                           ram_we;
  tag_store_pkg::index_t                             ram_index;
  tag_store_pkg::tag_entry_t                         ram_wdata;
  tag_store_pkg::tag_entry_t [`TS_NUM_WAYS-1:0]      ram_rdata;
  // Match and victim results
  tag_store_pkg::way_ind_t                           hit;
  tag_store_pkg::way_ind_t                           dirty;
  tag_store_pkg::way_ind_t                           victim;
  logic                                              evict;

  tag_store_ctrl i_ctrl (
    .clk_i       ( clk_i      ),
    .reset_i     ( reset_i    ),
    .req_i       ( req_i      ),
    .valid_i     ( valid_i    ),
    .ready_o     ( ready_o    ),
    .res_i       ( merged_res ),
    .wr_way_i    ( wr_way     ),
    .wr_entry_i  ( wr_entry   ),
    .valid_o     ( valid_o    ),
    .ready_i     ( ready_i    ),
    .res_o       ( res_o      ),
    .held_req_o  ( held_req   ),
    .ram_req_o   ( ram_req    ),
    .ram_we_o    ( ram_we     ),
    .ram_index_o ( ram_index  ),
    .ram_wdata_o ( ram_wdata  )
  );

  tag_ram i_tag_ram (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .req_i   ( ram_req   ),
    .we_i    ( ram_we    ),
    .index_i ( ram_index ),
    .wdata_i ( ram_wdata ),
    .rdata_o ( ram_rdata )
  );

  // Lock is sampled while the read data is valid
  tag_match i_tag_match (
    .entries_i ( ram_rdata    ),
    .req_tag_i ( held_req.tag ),
    .lock_i    ( spm_lock_i   ),
    .hit_o     ( hit          ),
    .dirty_o   ( dirty        )
  );

  victim_select i_victim_select (
    .entries_i ( ram_rdata  ),
    .lock_i    ( spm_lock_i ),
    .victim_o  ( victim     ),
    .evict_o   ( evict      )
  );

  response_merge i_response_merge (
    .op_i        ( held_req.op    ),
    .flush_way_i ( held_req.way   ),
    .req_tag_i   ( held_req.tag   ),
    .req_dirty_i ( held_req.dirty ),
    .hit_i       ( hit            ),
    .dirty_i     ( dirty          ),
    .victim_i    ( victim         ),
    .evict_i     ( evict          ),
    .entries_i   ( ram_rdata      ),
    .res_o       ( merged_res     ),
    .wr_way_o    ( wr_way         ),
    .wr_entry_o  ( wr_entry       )
  );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
/*
  Testbench clock and reset
  Free running clock with a period of 10, reset held high for the
  first 3 rising edges
*/
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Released just after the third edge, like any other driven input
  initial begin
    reset_o = 1'b1;
    repeat (3) @(posedge clk_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

/* testbench/tag_store_tb.sv */
/*
  Tag store testbench
  Directed and random lookups and flushes against a model of the
  tag array, with back-pressure and a watchdog
*/
`default_nettype none

`include "tag_store_config.svh"

module tag_store_tb;

  localparam int NUM_SETS     = 1 << `TS_INDEX_BITS;
  localparam int NUM_WAYS     = `TS_NUM_WAYS;
  localparam int NUM_DIRECTED = 25;
  localparam int NUM_RANDOM   = 300;
  // Generous budget of 40 cycles per request
  localparam int WATCHDOG_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 40;

  logic                      clk;
  logic                      reset;
  tag_store_pkg::way_ind_t   spm_lock;
  tag_store_pkg::store_req_t req_in;
  logic                      valid_in;
  logic                      ready;
  tag_store_pkg::store_res_t res;
  logic                      valid_out;
  logic                      ready_in;
  logic                      rand_ready;

  // Expected tag array, set then way
  tag_store_pkg::tag_entry_t model [NUM_SETS][NUM_WAYS];
  tag_store_pkg::store_res_t exp_q [$];
  tag_store_pkg::store_res_t exp_res;
  tag_store_pkg::store_res_t last_res;
  tag_store_pkg::store_res_t held_res;
  logic                      stalled;
  int unsigned               resp_count;
  int unsigned               checks;
  int unsigned               errors;
  int unsigned               test_base;
  int unsigned               tests_done;

  tb_clock_gen i_clock_gen (
    .clk_o   ( clk   ),
    .reset_o ( reset )
  );

  tag_store i_tag_store (
    .clk_i      ( clk       ),
    .reset_i    ( reset     ),
    .spm_lock_i ( spm_lock  ),
    .req_i      ( req_in    ),
    .valid_i    ( valid_in  ),
    .ready_o    ( ready     ),
    .res_o      ( res       ),
    .valid_o    ( valid_out ),
    .ready_i    ( ready_in  )
  );

  // Expected response for one request, updates the model as the store would
  function automatic tag_store_pkg::store_res_t predict(
    input tag_store_pkg::store_req_t req,
    input tag_store_pkg::way_ind_t   lock
  );
    tag_store_pkg::store_res_t res_m;
    tag_store_pkg::way_ind_t   hits;
    logic                      hit_dirty;
    int                        vic;
    res_m     = '0;
    hits      = '0;
    hit_dirty = 1'b0;
    vic       = -1;
    if (req.op == tag_store_pkg::OP_FLUSH) begin
      res_m.way = req.way;
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (req.way[w]) begin
          res_m.evict     = model[req.index][w].valid & model[req.index][w].dirty;
          res_m.evict_tag = model[req.index][w].tag;
          model[req.index][w] = '0;
        end
      end
      return res_m;
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (model[req.index][w].valid && model[req.index][w].tag == req.tag && !lock[w]) begin
        hits[w]   = 1'b1;
        hit_dirty = hit_dirty | model[req.index][w].dirty;
      end
    end
    if (hits != '0) begin
      res_m.way = hits;
      res_m.hit = 1'b1;
      // Promote only when no hitting line is dirty yet
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (hits[w] && req.dirty && !hit_dirty) begin
          model[req.index][w] = '{valid: 1'b1, dirty: 1'b1, tag: req.tag};
        end
      end
      return res_m;
    end
    // Victim order: invalid, then clean, then any unlocked way
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (vic < 0 && !lock[w] && !model[req.index][w].valid) vic = w;
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (vic < 0 && !lock[w] && !model[req.index][w].dirty) vic = w;
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (vic < 0 && !lock[w]) vic = w;
    end
    if (vic >= 0) begin
      res_m.way       = tag_store_pkg::way_ind_t'(1 << vic);
      res_m.evict     = model[req.index][vic].valid & model[req.index][vic].dirty;
      res_m.evict_tag = model[req.index][vic].tag;
      model[req.index][vic] = '{valid: 1'b1, dirty: req.dirty, tag: req.tag};
    end
    return res_m;
  endfunction

  function automatic tag_store_pkg::store_req_t make_req(
    input tag_store_pkg::store_op_e op,
    input tag_store_pkg::index_t    index,
    input tag_store_pkg::tag_t      tag,
    input logic                     dirty,
    input tag_store_pkg::way_ind_t  way
  );
    return '{op: op, index: index, tag: tag, dirty: dirty, way: way};
  endfunction

  task automatic expect_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("ERR %0t: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d errors", name, errors - test_base);
    test_base = errors;
    tests_done++;
  endtask

  // One request through the handshake, returns the cycles until valid_o
  task automatic send(
    input  tag_store_pkg::store_req_t req,
    input  tag_store_pkg::way_ind_t   lock,
    output int unsigned               latency
  );
    int unsigned target;
    @(posedge clk);
    #1;
    req_in   = req;
    valid_in = 1'b1;
    spm_lock = lock;
    @(negedge clk);
    while (!ready) @(negedge clk);
    // Accepted at the coming edge
    exp_q.push_back(predict(req, lock));
    target = resp_count + 1;
    @(posedge clk);
    #1;
    valid_in = 1'b0;
    @(negedge clk);
    latency = 1;
    while (!valid_out) begin
      @(negedge clk);
      latency++;
    end
    // Read cycle is over, a new lock must not move the held response
    @(posedge clk);
    #1;
    spm_lock = tag_store_pkg::way_ind_t'($urandom());
    while (resp_count != target) @(negedge clk);
  endtask

  // Response check on stable values, mid cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (stalled) begin
        checks++;
        assert (valid_out && res === held_res) else begin
          $display("ERR %0t: res_o changed under back-pressure, %h then %h",
                   $time, held_res, res);
          errors++;
        end
      end
      stalled  = valid_out && !ready_in;
      held_res = res;
      if (valid_out && ready_in) begin
        if (exp_q.size() == 0) begin
          $display("response seen at %0t with no request outstanding", $time);
          errors++;
        end else begin
          exp_res = exp_q.pop_front();
          checks++;
          assert (res === exp_res) else begin
            $display("ERR %0t: response %h, expected %h", $time, res, exp_res);
            errors++;
          end
        end
        last_res = res;
        resp_count++;
      end
    end
  end

  // Back-pressure, random only during the mixed test
  initial begin : drive_ready
    logic [31:0] rnd;
    ready_in = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      rnd      = $urandom();
      ready_in = rand_ready ? rnd[0] : 1'b1;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * 10);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial begin : main
    tag_store_pkg::store_req_t r;
    int unsigned               lat;
    logic [31:0]               rnd;
    void'($urandom(32'h9d39));
    spm_lock   = '0;
    req_in     = '0;
    valid_in   = 1'b0;
    rand_ready = 1'b0;
    stalled    = 1'b0;
    held_res   = '0;
    last_res   = '0;
    resp_count = 0;
    checks     = 0;
    errors     = 0;
    test_base  = 0;
    tests_done = 0;
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) model[s][w] = '0;
    end
    @(negedge clk);
    while (reset) @(negedge clk);

    expect_true(ready && !valid_out, "idle handshake state after reset");
    send(make_req(tag_store_pkg::OP_LOOKUP, 4'd1, 8'h11, 1'b0, 4'b0000), 4'b0000, lat);
    expect_true(lat == 2, "valid_o not 2 cycles after acceptance");
    expect_true(last_res.way == 4'b0001 && !last_res.evict && !last_res.hit,
                "first miss in empty set");
    end_test("test 1 reset and first miss");

    // Fill set 5 then hit every way
    for (int w = 0; w < NUM_WAYS; w++) begin
      send(make_req(tag_store_pkg::OP_LOOKUP, 4'd5, tag_store_pkg::tag_t'(8'hA0 + w),
                    1'b0, 4'b0000), 4'b0000, lat);
      expect_true(last_res.way == tag_store_pkg::way_ind_t'(1 << w), "fill order");
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      send(make_req(tag_store_pkg::OP_LOOKUP, 4'd5, tag_store_pkg::tag_t'(8'hA0 + w),
                    1'b0, 4'b0000), 4'b0000, lat);
      expect_true(last_res.hit && last_res.way == tag_store_pkg::way_ind_t'(1 << w),
                  "repeat hit way");
    end
    end_test("test 2 fill and hit");

    send(make_req(tag_store_pkg::OP_LOOKUP, 4'd5, 8'hA1, 1'b1, 4'b0000), 4'b0000, lat);
    send(make_req(tag_store_pkg::OP_FLUSH, 4'd5, 8'h00, 1'b0, 4'b0010), 4'b0000, lat);
    expect_true(last_res.evict && last_res.evict_tag == 8'hA1, "flush of promoted line");
    send(make_req(tag_store_pkg::OP_FLUSH, 4'd5, 8'h00, 1'b0, 4'b0010), 4'b0000, lat);
    expect_true(!last_res.evict, "second flush evicts");
    end_test("test 3 dirty promotion and flush");

    // All dirty set, then a set with one clean way
    for (int w = 0; w < NUM_WAYS; w++) begin
      send(make_req(tag_store_pkg::OP_LOOKUP, 4'd6, tag_store_pkg::tag_t'(8'hB0 + w),
                    1'b1, 4'b0000), 4'b0000, lat);
    end
    send(make_req(tag_store_pkg::OP_LOOKUP, 4'd6, 8'hB4, 1'b0, 4'b0000), 4'b0000, lat);
    expect_true(last_res.way == 4'b0001 && last_res.evict && last_res.evict_tag == 8'hB0,
                "all dirty victim");
    for (int w = 0; w < NUM_WAYS; w++) begin
      send(make_req(tag_store_pkg::OP_LOOKUP, 4'd7, tag_store_pkg::tag_t'(8'hC0 + w),
                    (w != 2), 4'b0000), 4'b0000, lat);
    end
    send(make_req(tag_store_pkg::OP_LOOKUP, 4'd7, 8'hC4, 1'b0, 4'b0000), 4'b0000, lat);
    expect_true(last_res.way == 4'b0100 && !last_res.evict, "clean way victim");
    end_test("test 4 replacement order");

    send(make_req(tag_store_pkg::OP_LOOKUP, 4'd5, 8'hA0, 1'b0, 4'b0000), 4'b0001, lat);
    expect_true(!last_res.hit && last_res.way != 4'b0001, "locked way used");
    send(make_req(tag_store_pkg::OP_LOOKUP, 4'd5, 8'hD0, 1'b0, 4'b0000), 4'b1111, lat);
    expect_true(last_res.way == 4'b0000 && !last_res.evict, "all locked lookup");
    send(make_req(tag_store_pkg::OP_LOOKUP, 4'd5, 8'hD0, 1'b0, 4'b0000), 4'b0000, lat);
    expect_true(!last_res.hit, "write with all ways locked");
    end_test("test 5 scratchpad locks");

    // Few sets and tags so hits and evictions are common
    rand_ready = 1'b1;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rnd     = $urandom();
      r.op    = (rnd[2:0] == 3'd0) ? tag_store_pkg::OP_FLUSH : tag_store_pkg::OP_LOOKUP;
      r.index = {2'b00, rnd[5:4]};
      r.tag   = {5'b00000, rnd[10:8]};
      r.dirty = rnd[11];
      r.way   = tag_store_pkg::way_ind_t'(1 << rnd[13:12]);
      send(r, (rnd[15:14] == 2'd0) ? rnd[19:16] : 4'b0000, lat);
    end
    rand_ready = 1'b0;
    end_test("test 6 random mix");

    $display("summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
hw/tag_store_pkg.sv
hw/tag_ram.sv
hw/tag_match.sv
hw/victim_select.sv
hw/response_merge.sv
hw/tag_store_ctrl.sv
hw/tag_store.sv
testbench/tb_clock_gen.sv
testbench/tag_store_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the tag store testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tag_store_tb -o tag_store_sim
./obj_dir/tag_store_sim > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
  exit 1
fi
exit 0
